//--- source/rv_csr_pkg.sv
//////////////////////////////
// shared types and constants of the CSR unit
// privilege levels, Zicsr operations, CSR address fields,
// trap causes and the implemented CSR addresses
//////////////////////////////

package rv_csr_pkg;

  //////////////////////////////
  // privilege and operations
  //////////////////////////////

  // privilege level, 2 is reserved
  typedef enum logic [1:0] {
    LVL_U = 2'd0,
    LVL_S = 2'd1,
    LVL_R = 2'd2,
    LVL_M = 2'd3
  } level_e;

  // Zicsr operation, 0 is not used
  typedef enum logic [1:0] {
    CSR_RW  = 2'd1,
    CSR_SET = 2'd2,
    CSR_CLR = 2'd3
  } csr_op_e;

  // trap source
  typedef enum logic {
    TRAP_ECALL  = 1'b0,
    TRAP_EBREAK = 1'b1
  } trap_typ_e;

  //////////////////////////////
  // CSR address
  //////////////////////////////

  // address convention fields
  typedef struct packed {
    logic [1:0] perm;
    level_e     level;
    logic [7:0] num;
  } csr_addr_s;

  // same 12 bits, raw index or convention fields
  typedef union packed {
    logic [11:0] a;
    csr_addr_s   s;
  } csr_addr_u;

  // perm field value of the read-only segment
  localparam logic [1:0] PERM_RO = 2'b11;

  // supervisor trap and scratch registers
  localparam logic [11:0] STVEC    = 12'h105;
  localparam logic [11:0] SSCRATCH = 12'h140;
  localparam logic [11:0] SEPC     = 12'h141;
  localparam logic [11:0] SCAUSE   = 12'h142;

  // machine trap setup and handling
  localparam logic [11:0] MEDELEG       = 12'h302;
  localparam logic [11:0] MTVEC         = 12'h305;
  localparam logic [11:0] MCOUNTINHIBIT = 12'h320;
  localparam logic [11:0] MSCRATCH      = 12'h340;
  localparam logic [11:0] MEPC          = 12'h341;
  localparam logic [11:0] MCAUSE        = 12'h342;

  // counters and hart id
  localparam logic [11:0] MCYCLE   = 12'hB00;
  localparam logic [11:0] MINSTRET = 12'hB02;
  localparam logic [11:0] MHARTID  = 12'hF14;

  //////////////////////////////
  // trap causes and tvec modes
  //////////////////////////////

  localparam logic [4:0] CAUSE_BREAK = 5'd3;
  localparam logic [4:0] CAUSE_UCALL = 5'd8;
  localparam logic [4:0] CAUSE_SCALL = 5'd9;
  localparam logic [4:0] CAUSE_MCALL = 5'd11;

  // low 2 bits of a tvec value
  localparam logic [1:0] TVEC_DIRECT   = 2'd0;
  localparam logic [1:0] TVEC_VECTORED = 2'd1;

endpackage

//--- source/csr_bus_if.sv
//////////////////////////////
// checked CSR access inside the unit
// the checker drives address, write strobe and new value,
// the store returns the old value
//////////////////////////////

interface csr_bus_if
  import rv_csr_pkg::*;
#(
  parameter int unsigned XLEN = 32
) ();

  // access address
  csr_addr_u       adr;
  // write strobe, already checked and trap gated
  logic            we;
  // new register value
  logic [XLEN-1:0] wval;
  // old register value
  logic [XLEN-1:0] rval;

  modport access (output adr, output we, output wval, input rval);
  modport store (input adr, input we, input wval, output rval);
  modport counter (input adr, input we, input wval);

endinterface

//--- source/csr_access.sv
//////////////////////////////
// Zicsr access check and value computation
// fully combinational, sits between the request ports
// and the register store / counters
//////////////////////////////

module csr_access
  import rv_csr_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic            ren_i,
  input  logic            wen_i,
  input  logic            imm_sel_i,
  input  logic            trap_i,
  input  csr_op_e         op_i,
  input  logic [4:0]      imm_i,
  input  logic [11:0]     adr_i,
  input  logic [XLEN-1:0] wdt_i,
  input  level_e          level_i,
  csr_bus_if.access       bus,
  output logic [XLEN-1:0] rdt_o,
  output logic            ill_o
);

  csr_addr_u       adr;
  logic            acc_ok;
  logic            wr_ok;
  logic [XLEN-1:0] msk;

  // same bits, field view used for the check
  assign adr = adr_i;
  assign bus.adr = adr;

  //////////////////////////////
  // address convention check
  //////////////////////////////

  // address level at or below current level
  assign acc_ok = (adr.s.level <= level_i);
  // writes also blocked in read-only segment
  assign wr_ok = acc_ok && (adr.s.perm != PERM_RO);

  // any denied part fails the whole request
  assign ill_o = (ren_i && !acc_ok) || (wen_i && !wr_ok);

  // denied reads return zero
  assign rdt_o = (ren_i && !ill_o) ? bus.rval : '0;

  // no write on a denied request or under a trap
  assign bus.we = wen_i && !ill_o && !trap_i;

  //////////////////////////////
  // new value
  //////////////////////////////

  // register operand or zero-extended immediate
  assign msk = imm_sel_i ? XLEN'(imm_i) : wdt_i;

  // old value comes back from the store mux
  always_comb begin
    case (op_i)
      CSR_RW:  bus.wval = msk;
      CSR_SET: bus.wval = bus.rval | msk;
      CSR_CLR: bus.wval = bus.rval & ~msk;
      // op 0 never comes with a write strobe
      default: bus.wval = msk;
    endcase
  end

endmodule

//--- source/csr_regfile.sv
//////////////////////////////
// trap and scratch CSR storage
// Zicsr writes from the bus, EPC / cause on traps,
// read mux for every readable CSR
//////////////////////////////

module csr_regfile
  import rv_csr_pkg::*;
#(
  parameter int unsigned XLEN    = 32,
  parameter int unsigned HART_ID = 0
) (
  input  logic            clk,
  input  logic            rst,
  csr_bus_if.store        bus,
  input  logic            trap_i,
  input  logic            trap_s_i,
  input  logic [4:0]      cause_i,
  input  logic [XLEN-1:0] epc_i,
  input  logic [XLEN-1:0] mcycle_i,
  input  logic [XLEN-1:0] minstret_i,
  output logic [XLEN-1:0] mcountinhibit_o,
  output logic [XLEN-1:0] medeleg_o,
  output logic [XLEN-1:0] mtvec_o,
  output logic [XLEN-1:0] stvec_o,
  output logic [XLEN-1:0] mepc_o,
  output logic [XLEN-1:0] sepc_o,
  output logic [XLEN-1:0] mcause_o,
  output logic [XLEN-1:0] scause_o
);

  // supervisor set
  logic [XLEN-1:0] sscratch;
  logic [XLEN-1:0] sepc;
  logic [XLEN-1:0] scause;
  logic [XLEN-1:0] stvec;
  // machine set
  logic [XLEN-1:0] medeleg;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mcountinhibit;
  logic [XLEN-1:0] mscratch;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  //////////////////////////////
  // register updates
  //////////////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      sscratch      <= '0;
      sepc          <= '0;
      scause        <= '0;
      stvec         <= '0;
      medeleg       <= '0;
      mtvec         <= '0;
      mcountinhibit <= '0;
      mscratch      <= '0;
      mepc          <= '0;
      mcause        <= '0;
    end else if (trap_i) begin
      // trap target level gets EPC and cause
      if (trap_s_i) begin
        sepc   <= epc_i;
        scause <= XLEN'(cause_i);
      end else begin
        mepc   <= epc_i;
        mcause <= XLEN'(cause_i);
      end
    end else if (bus.we) begin
      // raw index decode, other addresses drop the write
      case (bus.adr.a)
        SSCRATCH:      sscratch      <= bus.wval;
        SEPC:          sepc          <= bus.wval;
        SCAUSE:        scause        <= bus.wval;
        STVEC:         stvec         <= bus.wval;
        MEDELEG:       medeleg       <= bus.wval;
        MTVEC:         mtvec         <= bus.wval;
        MCOUNTINHIBIT: mcountinhibit <= bus.wval;
        MSCRATCH:      mscratch      <= bus.wval;
        MEPC:          mepc          <= bus.wval;
        MCAUSE:        mcause        <= bus.wval;
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  // unimplemented addresses read zero
  always_comb begin
    case (bus.adr.a)
      SSCRATCH:      bus.rval = sscratch;
      SEPC:          bus.rval = sepc;
      SCAUSE:        bus.rval = scause;
      STVEC:         bus.rval = stvec;
      MEDELEG:       bus.rval = medeleg;
      MTVEC:         bus.rval = mtvec;
      MCOUNTINHIBIT: bus.rval = mcountinhibit;
      MSCRATCH:      bus.rval = mscratch;
      MEPC:          bus.rval = mepc;
      MCAUSE:        bus.rval = mcause;
      // counters live outside
      MCYCLE:        bus.rval = mcycle_i;
      MINSTRET:      bus.rval = minstret_i;
      MHARTID:       bus.rval = XLEN'(HART_ID);
      default:       bus.rval = '0;
    endcase
  end

  // to trap logic and counters
  assign mcountinhibit_o = mcountinhibit;
  assign medeleg_o       = medeleg;
  assign mtvec_o         = mtvec;
  assign stvec_o         = stvec;
  assign mepc_o          = mepc;
  assign sepc_o          = sepc;
  assign mcause_o        = mcause;
  assign scause_o        = scause;

endmodule

//--- source/csr_trap.sv
//////////////////////////////
// privilege level and trap handling
// cause and delegation for ECALL / EBREAK,
// trap vector and EPC of the current level
//////////////////////////////

module csr_trap
  import rv_csr_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            trap_i,
  input  trap_typ_e       trap_typ_i,
  input  logic [XLEN-1:0] medeleg_i,
  input  logic [XLEN-1:0] mtvec_i,
  input  logic [XLEN-1:0] stvec_i,
  input  logic [XLEN-1:0] mepc_i,
  input  logic [XLEN-1:0] sepc_i,
  input  logic [XLEN-1:0] mcause_i,
  input  logic [XLEN-1:0] scause_i,
  output level_e          level_o,
  output logic            trap_s_o,
  output logic [4:0]      cause_o,
  output logic [XLEN-1:0] epc_o,
  output logic [XLEN-1:0] tvec_o
);

  level_e level;

  //////////////////////////////
  // cause and delegation
  //////////////////////////////

  // ECALL cause depends on the calling level
  always_comb begin
    if (trap_typ_i == TRAP_EBREAK) begin
      cause_o = CAUSE_BREAK;
    end else begin
      case (level)
        LVL_U:   cause_o = CAUSE_UCALL;
        LVL_S:   cause_o = CAUSE_SCALL;
        // reserved level never reached
        default: cause_o = CAUSE_MCALL;
      endcase
    end
  end

  // medeleg bit of the cause picks S
  assign trap_s_o = medeleg_i[cause_o];

  // only traps move the level, no xRET
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      level <= LVL_M;
    end else if (trap_i) begin
      level <= trap_s_o ? LVL_S : LVL_M;
    end
  end

  assign level_o = level;

  //////////////////////////////
  // vector and EPC
  //////////////////////////////

  // direct: base only, vectored: base + 4 * cause
  function automatic logic [XLEN-1:0] tvec_f(
    input logic [XLEN-1:0] tvec,
    input logic [XLEN-1:0] cause
  );
    logic [XLEN-1:0] base;
    base = {tvec[XLEN-1:2], 2'b00};
    // reserved modes treated as direct
    if (tvec[1:0] == TVEC_VECTORED) begin
      tvec_f = base + (cause << 2);
    end else begin
      tvec_f = base;
    end
  endfunction

  // S registers in S mode, machine set otherwise
  always_comb begin
    if (level == LVL_S) begin
      tvec_o = tvec_f(stvec_i, scause_i);
      epc_o  = sepc_i;
    end else begin
      tvec_o = tvec_f(mtvec_i, mcause_i);
      epc_o  = mepc_i;
    end
  end

endmodule

//--- source/csr_counters.sv
//////////////////////////////
// mcycle and minstret counters
// a CSR write replaces the increment of that cycle,
// mcountinhibit bits 0 and 2 stop counting
//////////////////////////////

module csr_counters
  import rv_csr_pkg::*;
#(
  parameter int unsigned XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            instret_i,
  input  logic [XLEN-1:0] mcountinhibit_i,
  csr_bus_if.counter      bus,
  output logic [XLEN-1:0] mcycle_o,
  output logic [XLEN-1:0] minstret_o
);

  // index 0 is mcycle, index 1 is minstret
  localparam logic [1:0][11:0] CNT_ADR = {MINSTRET, MCYCLE};

  logic [1:0][XLEN-1:0] cnt;
  logic [1:0]           inc;

  // cycle counts every clock, instret on retire pulses
  assign inc[0] = !mcountinhibit_i[0];
  assign inc[1] = instret_i && !mcountinhibit_i[2];

  for (genvar i = 0; i < 2; i++) begin : g_cnt
    always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
        cnt[i] <= '0;
      end else if (bus.we && (bus.adr.a == CNT_ADR[i])) begin
        // write has priority
        cnt[i] <= bus.wval;
      end else if (inc[i]) begin
        cnt[i] <= cnt[i] + XLEN'(1);
      end
    end
  end

  assign mcycle_o   = cnt[0];
  assign minstret_o = cnt[1];

endmodule

//--- source/rv_csr.sv
//////////////////////////////
// CSR unit top level for a small RV32 core
// Zicsr requests, ECALL / EBREAK traps and counters
//////////////////////////////

module rv_csr
  import rv_csr_pkg::*;
#(
  parameter int unsigned XLEN    = 32,
  parameter int unsigned HART_ID = 0
) (
  input  logic            clk,
  input  logic            rst,
  // Zicsr request
  input  logic            csr_ren_i,
  input  logic            csr_wen_i,
  input  logic            csr_imm_sel_i,
  input  csr_op_e         csr_op_i,
  input  logic [4:0]      csr_imm_i,
  input  logic [11:0]     csr_adr_i,
  input  logic [XLEN-1:0] csr_wdt_i,
  output logic [XLEN-1:0] csr_rdt_o,
  output logic            csr_ill_o,
  // trap
  input  logic            trap_i,
  input  trap_typ_e       trap_typ_i,
  input  logic [XLEN-1:0] epc_i,
  output logic [XLEN-1:0] epc_o,
  output logic [XLEN-1:0] tvec_o,
  // retire pulse
  input  logic            instret_i
);

  csr_bus_if #(.XLEN(XLEN)) bus ();

  level_e          level;
  logic            trap_s;
  logic [4:0]      cause;
  logic [XLEN-1:0] mcycle;
  logic [XLEN-1:0] minstret;
  logic [XLEN-1:0] mcountinhibit;
  logic [XLEN-1:0] medeleg;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] stvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] sepc;
  logic [XLEN-1:0] mcause;
  logic [XLEN-1:0] scause;

  csr_access #(.XLEN(XLEN)) i_csr_access (
    .ren_i     (csr_ren_i),
    .wen_i     (csr_wen_i),
    .imm_sel_i (csr_imm_sel_i),
    .trap_i    (trap_i),
    .op_i      (csr_op_i),
    .imm_i     (csr_imm_i),
    .adr_i     (csr_adr_i),
    .wdt_i     (csr_wdt_i),
    .level_i   (level),
    .bus       (bus.access),
    .rdt_o     (csr_rdt_o),
    .ill_o     (csr_ill_o)
  );

  csr_regfile #(.XLEN(XLEN), .HART_ID(HART_ID)) i_csr_regfile (
    .clk             (clk),
    .rst             (rst),
    .bus             (bus.store),
    .trap_i          (trap_i),
    .trap_s_i        (trap_s),
    .cause_i         (cause),
    .epc_i           (epc_i),
    .mcycle_i        (mcycle),
    .minstret_i      (minstret),
    .mcountinhibit_o (mcountinhibit),
    .medeleg_o       (medeleg),
    .mtvec_o         (mtvec),
    .stvec_o         (stvec),
    .mepc_o          (mepc),
    .sepc_o          (sepc),
    .mcause_o        (mcause),
    .scause_o        (scause)
  );

  csr_counters #(.XLEN(XLEN)) i_csr_counters (
    .clk             (clk),
    .rst             (rst),
    .instret_i       (instret_i),
    .mcountinhibit_i (mcountinhibit),
    .bus             (bus.counter),
    .mcycle_o        (mcycle),
    .minstret_o      (minstret)
  );

  csr_trap #(.XLEN(XLEN)) i_csr_trap (
    .clk        (clk),
    .rst        (rst),
    .trap_i     (trap_i),
    .trap_typ_i (trap_typ_i),
    .medeleg_i  (medeleg),
    .mtvec_i    (mtvec),
    .stvec_i    (stvec),
    .mepc_i     (mepc),
    .sepc_i     (sepc),
    .mcause_i   (mcause),
    .scause_i   (scause),
    .level_o    (level),
    .trap_s_o   (trap_s),
    .cause_o    (cause),
    .epc_o      (epc_o),
    .tvec_o     (tvec_o)
  );

endmodule

//--- verification/rv_csr_tb.sv
//////////////////////////////
// testbench for the CSR unit
// drives Zicsr requests, traps and retire pulses,
// a model of the CSR set is compared on every falling edge
//////////////////////////////

module rv_csr_tb
  import rv_csr_pkg::*;
();

  localparam int unsigned XLEN    = 32;
  localparam int unsigned HART_ID = 0;
  // the tests take about 100 cycles and the limit leaves a wide margin
  localparam int TIMEOUT = 2000;

  localparam logic [11:0] RW_LIST [4] = '{MSCRATCH, MTVEC, MEDELEG, SSCRATCH};
  localparam logic [11:0] ALL_LIST [10] = '{SSCRATCH, SEPC, SCAUSE, STVEC, MEDELEG,
                                            MTVEC, MCOUNTINHIBIT, MSCRATCH, MEPC, MCAUSE};

  logic        clk;
  logic        rst;
  logic        csr_ren;
  logic        csr_wen;
  logic        csr_imm_sel;
  csr_op_e     csr_op;
  logic [4:0]  csr_imm;
  logic [11:0] csr_adr;
  logic [31:0] csr_wdt;
  logic [31:0] csr_rdt;
  logic        csr_ill;
  logic        trap;
  trap_typ_e   trap_typ;
  logic [31:0] epc_in;
  logic [31:0] epc_out;
  logic [31:0] tvec;
  logic        instret;

  // model state indexed by csr_slot
  logic [31:0] m_csr [13];
  logic [1:0]  m_level;

  logic [31:0] rnd;
  string       test_name;
  int          err_cnt;
  int          chk_cnt;
  int          cyc_cnt;

  rv_csr #(.XLEN(XLEN), .HART_ID(HART_ID)) i_rv_csr (
    .clk           (clk),
    .rst           (rst),
    .csr_ren_i     (csr_ren),
    .csr_wen_i     (csr_wen),
    .csr_imm_sel_i (csr_imm_sel),
    .csr_op_i      (csr_op),
    .csr_imm_i     (csr_imm),
    .csr_adr_i     (csr_adr),
    .csr_wdt_i     (csr_wdt),
    .csr_rdt_o     (csr_rdt),
    .csr_ill_o     (csr_ill),
    .trap_i        (trap),
    .trap_typ_i    (trap_typ),
    .epc_i         (epc_in),
    .epc_o         (epc_out),
    .tvec_o        (tvec),
    .instret_i     (instret)
  );

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk;

  //////////////////////////////
  // reference model
  //////////////////////////////

  // slot of an implemented CSR or -1
  function automatic int csr_slot(input logic [11:0] adr);
    case (adr)
      SSCRATCH:      return 0;
      SEPC:          return 1;
      SCAUSE:        return 2;
      STVEC:         return 3;
      MEDELEG:       return 4;
      MTVEC:         return 5;
      MCOUNTINHIBIT: return 6;
      MSCRATCH:      return 7;
      MEPC:          return 8;
      MCAUSE:        return 9;
      MCYCLE:        return 10;
      MINSTRET:      return 11;
      MHARTID:       return 12;
      default:       return -1;
    endcase
  endfunction

  // address level bits 9:8 at or below current level
  function automatic logic access_ok(input logic [11:0] adr, input logic [1:0] lvl);
    return adr[9:8] <= lvl;
  endfunction

  // bits 11:10 all ones is the read-only segment
  function automatic logic write_ok(input logic [11:0] adr, input logic [1:0] lvl);
    return access_ok(adr, lvl) && (adr[11:10] != 2'b11);
  endfunction

  function automatic logic [31:0] expected_read(input logic [11:0] adr);
    int s;
    s = csr_slot(adr);
    if (s < 0) begin
      return '0;
    end
    return m_csr[s];
  endfunction

  function automatic logic [31:0] new_value(input csr_op_e op, input logic [31:0] old,
                                            input logic [31:0] msk);
    case (op)
      CSR_SET: return old | msk;
      CSR_CLR: return old & ~msk;
      default: return msk;
    endcase
  endfunction

  // ebreak 3 and ecall 8 / 9 / 11 by calling level
  function automatic logic [4:0] trap_cause(input trap_typ_e typ, input logic [1:0] lvl);
    if (typ == TRAP_EBREAK) begin
      return 5'd3;
    end
    case (lvl)
      2'd0:    return 5'd8;
      2'd1:    return 5'd9;
      default: return 5'd11;
    endcase
  endfunction

  // mode 1 adds 4 * cause to the base
  function automatic logic [31:0] vector_addr(input logic [31:0] tv, input logic [31:0] cause);
    logic [31:0] base;
    base = {tv[31:2], 2'b00};
    if (tv[1:0] == 2'd1) begin
      return base + cause * 32'd4;
    end
    return base;
  endfunction

  function automatic logic [31:0] expected_tvec();
    if (m_level == 2'd1) begin
      return vector_addr(m_csr[3], m_csr[2]);
    end
    return vector_addr(m_csr[5], m_csr[9]);
  endfunction

  function automatic logic [31:0] expected_epc();
    return (m_level == 2'd1) ? m_csr[1] : m_csr[8];
  endfunction

  always @(posedge clk or posedge rst) begin : model
    logic [31:0] msk;
    logic [31:0] nval;
    logic [4:0]  cause;
    logic        wr;
    int          slot;
    if (rst) begin
      for (int i = 0; i < 12; i++) begin
        m_csr[i] <= '0;
      end
      m_csr[12] <= HART_ID;
      m_level   <= 2'd3;
    end else begin
      msk   = csr_imm_sel ? {27'b0, csr_imm} : csr_wdt;
      nval  = new_value(csr_op, expected_read(csr_adr), msk);
      slot  = csr_slot(csr_adr);
      wr    = csr_wen && write_ok(csr_adr, m_level) && !trap;
      cause = trap_cause(trap_typ, m_level);
      // counters first so that a write further down replaces the increment
      if (!m_csr[6][0]) begin
        m_csr[10] <= m_csr[10] + 32'd1;
      end
      if (instret && !m_csr[6][2]) begin
        m_csr[11] <= m_csr[11] + 32'd1;
      end
      if (trap) begin
        // medeleg bit of the cause sends it to S
        if (m_csr[4][cause]) begin
          m_csr[1] <= epc_in;
          m_csr[2] <= {27'b0, cause};
          m_level  <= 2'd1;
        end else begin
          m_csr[8] <= epc_in;
          m_csr[9] <= {27'b0, cause};
          m_level  <= 2'd3;
        end
      end else if (wr && slot >= 0) begin
        m_csr[slot] <= nval;
      end
    end
  end

  //////////////////////////////
  // checking
  //////////////////////////////

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin : compare
    logic [31:0] exp_rdt;
    logic        exp_ill;
    if (!rst) begin
      exp_ill = (csr_ren && !access_ok(csr_adr, m_level)) ||
                (csr_wen && !write_ok(csr_adr, m_level));
      exp_rdt = (csr_ren && !exp_ill) ? expected_read(csr_adr) : '0;
      check_value("csr_rdt_o", exp_rdt, csr_rdt);
      check_value("csr_ill_o", {31'b0, exp_ill}, {31'b0, csr_ill});
      check_value("epc_o", expected_epc(), epc_out);
      check_value("tvec_o", expected_tvec(), tvec);
    end
  end

  always @(posedge clk) begin
    cyc_cnt++;
    if (cyc_cnt >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic drive_req(input logic ren, input logic wen, input csr_op_e op,
                           input logic [11:0] adr, input logic [31:0] wdt,
                           input logic imm_sel, input logic [4:0] imm);
    @(posedge clk);
    csr_ren     <= ren;
    csr_wen     <= wen;
    csr_op      <= op;
    csr_adr     <= adr;
    csr_wdt     <= wdt;
    csr_imm_sel <= imm_sel;
    csr_imm     <= imm;
    trap        <= 1'b0;
  endtask

  task automatic go_idle();
    drive_req(1'b0, 1'b0, CSR_RW, '0, '0, 1'b0, '0);
  endtask

  task automatic write_csr(input logic [11:0] adr, input logic [31:0] val);
    drive_req(1'b0, 1'b1, CSR_RW, adr, val, 1'b0, '0);
  endtask

  task automatic read_csr(input logic [11:0] adr, output logic [31:0] val);
    drive_req(1'b1, 1'b0, CSR_RW, adr, '0, 1'b0, '0);
    @(negedge clk);
    val = csr_rdt;
  endtask

  // trap for one cycle with an optional write in the same cycle
  task automatic raise_trap(input trap_typ_e typ, input logic [31:0] pc, input logic wen,
                            input logic [11:0] adr, input logic [31:0] wdt);
    @(posedge clk);
    csr_ren     <= 1'b0;
    csr_wen     <= wen;
    csr_op      <= CSR_RW;
    csr_adr     <= adr;
    csr_wdt     <= wdt;
    csr_imm_sel <= 1'b0;
    trap        <= 1'b1;
    trap_typ    <= typ;
    epc_in      <= pc;
    @(posedge clk);
    trap        <= 1'b0;
    csr_wen     <= 1'b0;
  endtask

  initial begin : stimulus
    logic [31:0] val;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp;
    logic [31:0] base;
    logic [31:0] pc;
    rst         <= 1'b1;
    csr_ren     <= 1'b0;
    csr_wen     <= 1'b0;
    csr_imm_sel <= 1'b0;
    csr_op      <= CSR_RW;
    csr_imm     <= '0;
    csr_adr     <= '0;
    csr_wdt     <= '0;
    trap        <= 1'b0;
    trap_typ    <= TRAP_ECALL;
    epc_in      <= '0;
    instret     <= 1'b0;
    rnd         = 32'd26718;
    err_cnt     = 0;
    chk_cnt     = 0;
    cyc_cnt     = 0;
    test_name   = "reset";
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // machine mode read / write / set / clear
    test_name = "rw_set_clr";
    foreach (RW_LIST[i]) begin
      rnd = next_random(rnd);
      exp = rnd;
      write_csr(RW_LIST[i], exp);
      read_csr(RW_LIST[i], val);
      check_value("readback", exp, val);
    end
    rnd = next_random(rnd);
    exp = rnd;
    write_csr(MSCRATCH, exp);
    rnd = next_random(rnd);
    drive_req(1'b1, 1'b1, CSR_SET, MSCRATCH, rnd, 1'b0, '0);
    exp = exp | rnd;
    rnd = next_random(rnd);
    drive_req(1'b1, 1'b1, CSR_CLR, MSCRATCH, rnd, 1'b0, '0);
    exp = exp & ~rnd;
    rnd = next_random(rnd);
    drive_req(1'b1, 1'b1, CSR_SET, MSCRATCH, '0, 1'b1, rnd[4:0]);
    exp = exp | {27'b0, rnd[4:0]};
    rnd = next_random(rnd);
    drive_req(1'b1, 1'b1, CSR_CLR, MSCRATCH, '0, 1'b1, rnd[4:0]);
    exp = exp & ~{27'b0, rnd[4:0]};
    read_csr(MSCRATCH, val);
    check_value("set / clear result", exp, val);
    read_csr(MHARTID, val);
    check_value("mhartid", 32'd0, val);
    drive_req(1'b0, 1'b1, CSR_RW, MHARTID, rnd, 1'b0, '0);
    @(negedge clk);
    check_value("mhartid write ill", 32'd1, {31'b0, csr_ill});
    read_csr(MHARTID, val);
    check_value("mhartid after write", 32'd0, val);

    // unimplemented address then a sweep of all others against the model
    test_name = "unimplemented";
    rnd = next_random(rnd);
    write_csr(12'h3C0, rnd);
    read_csr(12'h3C0, val);
    check_value("unimplemented read", 32'd0, val);
    foreach (ALL_LIST[i]) begin
      read_csr(ALL_LIST[i], val);
    end

    // mcycle running and inhibited, minstret after write
    test_name = "counters";
    write_csr(MCOUNTINHIBIT, 32'd0);
    read_csr(MCYCLE, a);
    repeat (6) go_idle();
    read_csr(MCYCLE, b);
    check_value("mcycle delta", 32'd7, b - a);
    write_csr(MCOUNTINHIBIT, 32'd1);
    read_csr(MCYCLE, a);
    repeat (6) go_idle();
    read_csr(MCYCLE, b);
    check_value("mcycle inhibited", 32'd0, b - a);
    rnd = next_random(rnd);
    write_csr(MINSTRET, rnd);
    go_idle();
    // five pulses with gaps
    for (int k = 0; k < 10; k++) begin
      @(posedge clk);
      instret <= (k % 2 == 0);
    end
    read_csr(MINSTRET, val);
    check_value("minstret", rnd + 32'd5, val);
    write_csr(MCOUNTINHIBIT, 32'd0);

    // traps taken in M with direct then vectored mode
    test_name = "trap_m";
    write_csr(MEDELEG, 32'd0);
    rnd = next_random(rnd);
    base = rnd & ~32'd3;
    write_csr(MTVEC, base);
    rnd = next_random(rnd);
    pc = rnd & ~32'd3;
    raise_trap(TRAP_ECALL, pc, 1'b0, '0, '0);
    @(negedge clk);
    check_value("epc_o", pc, epc_out);
    check_value("tvec_o direct", base, tvec);
    read_csr(MEPC, val);
    check_value("mepc", pc, val);
    read_csr(MCAUSE, val);
    check_value("mcause ecall", 32'd11, val);
    write_csr(MTVEC, base | 32'd1);
    rnd = next_random(rnd);
    pc = rnd & ~32'd3;
    raise_trap(TRAP_EBREAK, pc, 1'b0, '0, '0);
    @(negedge clk);
    check_value("tvec_o vectored", base + 32'd12, tvec);
    read_csr(MCAUSE, val);
    check_value("mcause ebreak", 32'd3, val);

    // ECALL delegated to S
    test_name = "trap_s";
    write_csr(MEDELEG, 32'h800);
    rnd = next_random(rnd);
    base = rnd & ~32'd3;
    write_csr(STVEC, base | 32'd1);
    rnd = next_random(rnd);
    pc = rnd & ~32'd3;
    raise_trap(TRAP_ECALL, pc, 1'b0, '0, '0);
    @(negedge clk);
    check_value("epc_o", pc, epc_out);
    check_value("tvec_o", base + 32'd44, tvec);
    read_csr(SEPC, val);
    check_value("sepc", pc, val);
    read_csr(SCAUSE, val);
    check_value("scause", 32'd11, val);
    read_csr(MSCRATCH, val);
    check_value("machine read in S", 32'd0, val);
    check_value("machine read ill", 32'd1, {31'b0, csr_ill});
    rnd = next_random(rnd);
    write_csr(SSCRATCH, rnd);
    read_csr(SSCRATCH, val);
    check_value("sscratch", rnd, val);
    // cause 9 is not delegated so the trap goes back to M
    raise_trap(TRAP_ECALL, pc + 32'd4, 1'b0, '0, '0);
    read_csr(MCAUSE, val);
    check_value("mcause from S", 32'd9, val);

    // write in the trap cycle is dropped
    test_name = "trap_write";
    rnd = next_random(rnd);
    a = rnd;
    write_csr(MSCRATCH, a);
    rnd = next_random(rnd);
    raise_trap(TRAP_EBREAK, pc, 1'b1, MSCRATCH, rnd);
    read_csr(MSCRATCH, b);
    check_value("mscratch kept", a, b);
    read_csr(MEPC, val);
    check_value("mepc", pc, val);
    read_csr(MCAUSE, val);
    check_value("mcause", 32'd3, val);

    go_idle();
    @(negedge clk);
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- rv_csr.f
source/rv_csr_pkg.sv
source/csr_bus_if.sv
source/csr_access.sv
source/csr_regfile.sv
source/csr_trap.sv
source/csr_counters.sv
source/rv_csr.sv
verification/rv_csr_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the CSR unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module rv_csr_tb -f rv_csr.f

out=$(./obj_dir/Vrv_csr_tb)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
